//--- vlog.f
hdl/axi_rd_pkg.sv
hdl/frame_map_pkg.sv
hdl/vsync_frame_sel.sv
hdl/burst_addr_gen.sv
hdl/rd_beat_sink.sv
hdl/frame_rd_top.sv
verif/axi_rd_slave.sv
verif/tb_frame_rd.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the frame read engine testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_frame_rd \
    -f vlog.f \
    -o tb_frame_rd

./obj_dir/tb_frame_rd > sim.log 2>&1
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    exit 0
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi

//--- verif/tb_frame_rd.sv
`timescale 1ns/1ps

module tb_frame_rd;

    localparam int timeout_cycles = 2000;

    logic                  clk;
    logic                  rst;
    logic                  vsync;
    logic                  arready;
    logic                  credit_ret;
    logic                  overrun;
    logic                  stall_en;       // slave inserts random gaps
    logic                  hold_credits;   // sink keeps its buffer full
    axi_rd_pkg::ar_req_t   ar;
    axi_rd_pkg::r_beat_t   r;
    axi_rd_pkg::pix_beat_t pix;

    axi_rd_pkg::ar_req_t   ar_q[$];    // AR handshakes seen
    axi_rd_pkg::pix_beat_t pix_q[$];   // pix beats seen
    int                    held;       // beats in the sink whose credit is still out
    int                    errors;
    int                    checks;
    int                    tests;
    int                    failed_tests;
    logic [1:0]            exp_slot;   // slot of the next accepted frame

    frame_rd_top dut (
        .clk        (clk),
        .rst        (rst),
        .vsync      (vsync),
        .ar         (ar),
        .arready    (arready),
        .r          (r),
        .pix        (pix),
        .credit_ret (credit_ret),
        .overrun    (overrun)
    );

    axi_rd_slave u_slave (
        .clk      (clk),
        .rst      (rst),
        .stall_en (stall_en),
        .ar       (ar),
        .arready  (arready),
        .r        (r)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // display sink that records AR and pix traffic and returns one credit per beat
    initial begin : sink_monitor
        logic                  rst_s;
        logic                  got_ar;
        axi_rd_pkg::ar_req_t   ar_s;
        axi_rd_pkg::pix_beat_t pix_s;
        credit_ret = 1'b0;
        held       = 0;
        forever begin
            @(negedge clk);
            rst_s  = rst;
            got_ar = ar.valid && arready;
            ar_s   = ar;
            pix_s  = pix;
            @(posedge clk);
            #2;
            if (!rst_s) begin
                held       = 0;
                credit_ret = 1'b0;
            end else begin
                if (got_ar) ar_q.push_back(ar_s);
                if (pix_s.valid) pix_q.push_back(pix_s);
                if (credit_ret) held--;   // pulse taken at this edge
                if (pix_s.valid) held++;
                credit_ret = !hold_credits && held > 0;
            end
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #2 rst = 1'b0;
        repeat (4) @(posedge clk);
        #2 rst = 1'b1;
        exp_slot = 2'd0;
    endtask

    task automatic pulse_vsync();
        @(posedge clk);
        #2 vsync = 1'b1;
        repeat (2) @(posedge clk);
        #2 vsync = 1'b0;
    endtask

    task automatic clear_seen();
        @(posedge clk);
        ar_q.delete();
        pix_q.delete();
    endtask

    // on_pix picks the pix queue, else the AR queue
    task automatic wait_seen(input bit on_pix, input int n);
        int cnt;
        cnt = 0;
        while ((on_pix ? pix_q.size() : ar_q.size()) < n && cnt < timeout_cycles) begin
            @(posedge clk);
            cnt++;
        end
        if ((on_pix ? pix_q.size() : ar_q.size()) < n) begin
            errors++;
            $display("timeout: %0d %s never seen within %0d cycles",
                     n, on_pix ? "pix beats" : "AR handshakes", timeout_cycles);
        end
    endtask

    task automatic wait_drained();
        int cnt;
        cnt = 0;
        while (held > 0 && cnt < timeout_cycles) begin
            @(posedge clk);
            cnt++;
        end
        if (held > 0) begin
            errors++;
            $display("timeout: sink credits not all returned, %0d still held", held);
        end
        repeat (5) @(posedge clk);   // spacing between frames
    endtask

    task automatic check_frame(input logic [1:0] slot);
        logic [31:0] a;
        check_value("ar count", 64'(ar_q.size()), 64'(frame_map_pkg::frame_bursts));
        check_value("pix count", 64'(pix_q.size()), 64'(frame_map_pkg::frame_beats));
        foreach (ar_q[i]) begin
            a = 32'(slot) * 32'd4096 + 32'(i) * 32'd32;
            check_value($sformatf("ar[%0d].addr", i), 64'(ar_q[i].addr), 64'(a));
            check_value($sformatf("ar[%0d].id", i), 64'(ar_q[i].id), 64'(slot));
        end
        foreach (pix_q[k]) begin
            a = 32'(slot) * 32'd4096 + 32'(k) * 32'd8;
            check_value($sformatf("pix[%0d].data", k), pix_q[k].data, {a, ~a});
            check_value($sformatf("pix[%0d].slot", k), 64'(pix_q[k].slot), 64'(slot));
            check_value($sformatf("pix[%0d].sof", k), 64'(pix_q[k].sof), 64'(k == 0));
            check_value($sformatf("pix[%0d].eof", k), 64'(pix_q[k].eof),
                        64'(k == frame_map_pkg::frame_beats - 1));
        end
        exp_slot = (exp_slot == 2'd3) ? 2'd0 : exp_slot + 2'd1;
    endtask

    task automatic run_frame();
        clear_seen();
        pulse_vsync();
        wait_seen(1'b1, frame_map_pkg::frame_beats);
        check_frame(exp_slot);
        wait_drained();
    endtask

    task automatic end_test(input string name, input int e0);
        tests++;
        if (errors == e0) begin
            $display("test %s passed", name);
        end else begin
            failed_tests++;
            $display("test %s failed with %0d errors", name, errors - e0);
        end
    endtask

    task automatic test_reset_state();
        int e0;
        e0 = errors;
        @(negedge clk);
        check_value("ar.valid", 64'(ar.valid), 64'(0));
        check_value("pix.valid", 64'(pix.valid), 64'(0));
        check_value("overrun", 64'(overrun), 64'(0));
        clear_seen();
        repeat (20) @(posedge clk);
        check_value("ar count without vsync", 64'(ar_q.size()), 64'(0));
        end_test("reset_state", e0);
    endtask

    task automatic test_single_frame();
        int e0;
        e0 = errors;
        run_frame();
        end_test("single_frame", e0);
    endtask

    task automatic test_slot_rotation();
        int e0;
        e0 = errors;
        apply_reset();
        repeat (5) run_frame();   // slots 0 1 2 3 0
        end_test("slot_rotation", e0);
    endtask

    task automatic test_credit_hold();
        int e0;
        e0 = errors;
        clear_seen();
        hold_credits = 1'b1;
        pulse_vsync();
        wait_seen(1'b0, frame_map_pkg::credit_init / frame_map_pkg::burst_len);
        repeat (40) @(posedge clk);
        check_value("ar count with credits held", 64'(ar_q.size()), 64'(4));
        hold_credits = 1'b0;
        wait_seen(1'b1, frame_map_pkg::frame_beats);
        check_frame(exp_slot);
        wait_drained();
        end_test("credit_hold", e0);
    endtask

    task automatic test_overrun();
        int e0;
        e0 = errors;
        clear_seen();
        pulse_vsync();
        wait_seen(1'b0, 1);
        @(negedge clk);
        check_value("overrun", 64'(overrun), 64'(0));   // accepted frames leave it low
        pulse_vsync();   // lands while the frame is in flight
        wait_seen(1'b1, frame_map_pkg::frame_beats);
        @(negedge clk);
        check_value("overrun", 64'(overrun), 64'(1));
        check_frame(exp_slot);
        wait_drained();
        run_frame();   // dropped start must not use up a slot
        @(negedge clk);
        check_value("overrun", 64'(overrun), 64'(1));   // sticky until reset
        end_test("overrun", e0);
    endtask

    task automatic test_slave_stalls();
        int e0;
        e0 = errors;
        stall_en = 1'b1;
        repeat (2) run_frame();
        stall_en = 1'b0;
        end_test("slave_stalls", e0);
    endtask

    initial begin
        rst          = 1'b0;
        vsync        = 1'b0;
        stall_en     = 1'b0;
        hold_credits = 1'b0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        failed_tests = 0;
        exp_slot     = 2'd0;
        apply_reset();
        test_reset_state();
        test_single_frame();
        test_slot_rotation();
        test_credit_hold();
        test_overrun();
        test_slave_stalls();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verif/axi_rd_slave.sv
`timescale 1ns/1ps

// AXI read slave model
// INCR bursts of 4 beats of 8 bytes, data returned in order
module axi_rd_slave (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall_en,   // random arready and r gaps
    input  axi_rd_pkg::ar_req_t ar,
    output logic                arready,
    output axi_rd_pkg::r_beat_t r
);

    axi_rd_pkg::ar_req_t burst_q[$];   // accepted bursts, oldest first
    logic [31:0]         seed;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // address of the beat in the upper word, its inverse below
    function automatic logic [63:0] beat_data(input logic [31:0] burst_addr, input int beat);
        frame_map_pkg::frame_addr_u a;
        a.flat   = burst_addr;
        a.f.beat = 2'(beat);
        return {a.flat, ~a.flat};
    endfunction

    initial begin : model
        logic                rst_s;
        logic                take_ar;
        logic                beat_done;
        axi_rd_pkg::ar_req_t ar_s;
        int                  beat;
        arready = 1'b0;
        r       = '0;
        seed    = 32'h536b_7fed;
        beat    = 0;
        forever begin
            // handshakes of the coming edge are settled by mid cycle
            @(negedge clk);
            rst_s     = rst;
            take_ar   = ar.valid && arready;
            ar_s      = ar;
            beat_done = r.valid;
            @(posedge clk);
            #2;
            if (!rst_s) begin
                burst_q.delete();
                beat    = 0;
                arready = 1'b0;
                r       = '0;
            end else begin
                if (beat_done) begin
                    if (beat == frame_map_pkg::burst_len - 1) begin
                        beat = 0;
                        void'(burst_q.pop_front());   // burst complete
                    end else begin
                        beat++;
                    end
                end
                if (take_ar) begin
                    burst_q.push_back(ar_s);
                end
                seed    = lcg_next(seed);
                arready = !(stall_en && seed[31:30] == 2'b00);   // about 1 in 4 stalled
                seed    = lcg_next(seed);
                if (burst_q.size() > 0 && !(stall_en && seed[31:30] == 2'b00)) begin
                    r = '{valid: 1'b1, data: beat_data(burst_q[0].addr, beat),
                          id: burst_q[0].id, last: beat == frame_map_pkg::burst_len - 1};
                end else begin
                    r = '0;
                end
            end
        end
    end

endmodule

//--- hdl/frame_rd_top.sv
`timescale 1ns/1ps

// frame buffer read engine
// decode -> execute -> result, AXI read port in the middle
module frame_rd_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  vsync,
    output axi_rd_pkg::ar_req_t   ar,
    input  logic                  arready,
    input  axi_rd_pkg::r_beat_t   r,
    output axi_rd_pkg::pix_beat_t pix,
    input  logic                  credit_ret,   // one per freed sink beat
    output logic                  overrun
);

    frame_map_pkg::frame_cmd_t cmd;
    logic                      busy;
    logic                      frame_end;

    vsync_frame_sel u_sel (
        .clk     (clk),
        .rst     (rst),
        .vsync   (vsync),
        .busy    (busy),
        .cmd     (cmd),
        .overrun (overrun)
    );

    burst_addr_gen u_addr (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .busy       (busy),
        .ar         (ar),
        .arready    (arready),
        .credit_ret (credit_ret),
        .frame_end  (frame_end)
    );

    // data returns in order so no id lookup is needed
    rd_beat_sink u_sink (
        .clk       (clk),
        .rst       (rst),
        .r         (r),
        .pix       (pix),
        .frame_end (frame_end)
    );

endmodule

//--- hdl/rd_beat_sink.sv
`timescale 1ns/1ps

// result stage
// registers r beats, tags sof/eof, reports frame end
module rd_beat_sink (
    input  logic                   clk,
    input  logic                   rst,
    input  axi_rd_pkg::r_beat_t    r,
    output axi_rd_pkg::pix_beat_t  pix,
    output logic                   frame_end
);

    logic [frame_map_pkg::beat_cnt_w-1:0] beat_cnt;   // beat within frame
    logic                                 pix_valid;
    logic                                 pix_sof;
    logic                                 pix_eof;
    logic [axi_rd_pkg::data_w-1:0]        pix_data;
    logic [axi_rd_pkg::id_w-1:0]          pix_slot;
    logic                                 first_beat;
    logic                                 final_beat;

    assign first_beat = beat_cnt == '0;
    assign final_beat = beat_cnt == frame_map_pkg::beat_cnt_w'(frame_map_pkg::frame_beats - 1);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            beat_cnt  <= '0;
            pix_valid <= 1'b0;
            pix_sof   <= 1'b0;
            pix_eof   <= 1'b0;
        end else begin
            pix_valid <= r.valid;
            pix_sof   <= r.valid && first_beat;
            pix_eof   <= r.valid && final_beat;
            if (r.valid) begin
                if (final_beat) begin
                    beat_cnt <= '0;
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

    // beat payload, slot comes back on the AXI id
    always_ff @(posedge clk) begin
        if (r.valid) begin
            pix_data <= r.data;
            pix_slot <= r.id;
        end
    end

    assign pix = '{valid: pix_valid, data: pix_data, slot: pix_slot,
                   sof: pix_sof, eof: pix_eof};

    assign frame_end = pix_eof;   // same cycle as the eof beat

    // slave must close each burst exactly on beat 3, 7, 11 ...
    a_last_align: assert property (
        @(posedge clk) disable iff (!rst)
        r.valid |-> r.last == ((beat_cnt % frame_map_pkg::beat_cnt_w'(frame_map_pkg::burst_len))
                               == frame_map_pkg::beat_cnt_w'(frame_map_pkg::burst_len - 1))
    );

endmodule

//--- hdl/burst_addr_gen.sv
`timescale 1ns/1ps

// execute stage
// walks the 8 bursts of a frame, issues AR under credit control
module burst_addr_gen (
    input  logic                      clk,
    input  logic                      rst,
    input  frame_map_pkg::frame_cmd_t cmd,
    output logic                      busy,
    output axi_rd_pkg::ar_req_t       ar,
    input  logic                      arready,
    input  logic                      credit_ret,
    input  logic                      frame_end
);

    logic [frame_map_pkg::slot_w-1:0]      slot_q;      // slot of frame in flight
    logic [frame_map_pkg::burst_idx_w-1:0] burst_idx;   // burst on ar or next to raise
    logic                                  rd_act;      // bursts left to issue
    logic                                  ar_valid;
    logic [axi_rd_pkg::addr_w-1:0]         ar_addr;
    logic [axi_rd_pkg::id_w-1:0]           ar_id;
    logic [frame_map_pkg::credit_w-1:0]    credit_cnt;
    logic [frame_map_pkg::credit_w-1:0]    credit_nxt;
    logic                                  ar_hs;
    logic                                  last_burst;
    logic                                  credit_ok;
    logic                                  load_ar;
    logic [frame_map_pkg::slot_w-1:0]      slot_sel;
    logic [frame_map_pkg::burst_idx_w-1:0] idx_sel;
    frame_map_pkg::frame_addr_u            addr_nxt;

    always_comb begin
        ar_hs      = ar_valid && arready;
        last_burst = burst_idx == frame_map_pkg::burst_idx_w'(frame_map_pkg::frame_bursts - 1);

        // credits after this cycle, +1 per returned beat, -burst_len per AR
        credit_nxt = credit_cnt + frame_map_pkg::credit_w'(credit_ret);
        if (ar_hs) begin
            credit_nxt = credit_nxt - frame_map_pkg::credit_w'(frame_map_pkg::burst_len);
        end
        credit_ok = credit_nxt >= frame_map_pkg::credit_w'(frame_map_pkg::burst_len);

        // slot/index of the request that would sit on ar next cycle
        slot_sel = cmd.valid ? cmd.slot : slot_q;
        if (cmd.valid) begin
            idx_sel = '0;
        end else if (ar_hs) begin
            idx_sel = burst_idx + 1'b1;
        end else begin
            idx_sel = burst_idx;
        end

        addr_nxt.flat    = '0;
        addr_nxt.f.slot  = slot_sel;
        addr_nxt.f.burst = idx_sel;   // beat and byte offset stay zero

        load_ar = cmd.valid || !ar_valid || ar_hs;   // never while stalled
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            slot_q     <= '0;
            burst_idx  <= '0;
            rd_act     <= 1'b0;
            busy       <= 1'b0;
            ar_valid   <= 1'b0;
            credit_cnt <= frame_map_pkg::credit_w'(frame_map_pkg::credit_init);
        end else begin
            credit_cnt <= credit_nxt;
            if (cmd.valid) begin
                slot_q    <= cmd.slot;
                burst_idx <= '0;
                rd_act    <= 1'b1;
                busy      <= 1'b1;
                ar_valid  <= credit_ok;   // else wait for credits
            end else begin
                if (frame_end) begin
                    busy <= 1'b0;   // last beat delivered
                end
                if (ar_hs && last_burst) begin
                    rd_act   <= 1'b0;   // all 8 issued, busy holds until frame_end
                    ar_valid <= 1'b0;
                end else if (rd_act && (ar_hs || !ar_valid)) begin
                    if (ar_hs) begin
                        burst_idx <= burst_idx + 1'b1;
                    end
                    ar_valid <= credit_ok;
                end
            end
        end
    end

    // address and id only
    always_ff @(posedge clk) begin
        if (load_ar) begin
            ar_addr <= addr_nxt.flat;
            ar_id   <= slot_sel;
        end
    end

    assign ar = '{valid: ar_valid, addr: ar_addr, id: ar_id};

    // request held unchanged until the slave takes it
    a_ar_hold: assert property (
        @(posedge clk) disable iff (!rst)
        ar_valid && !arready |=> ar_valid && $stable(ar_addr) && $stable(ar_id)
    );

    // sink never returns more credits than it was given
    a_credit_max: assert property (
        @(posedge clk) disable iff (!rst)
        credit_cnt <= frame_map_pkg::credit_w'(frame_map_pkg::credit_init)
    );

endmodule

//--- hdl/vsync_frame_sel.sv
`timescale 1ns/1ps

// decode stage
// vsync sync + rising edge, slot rotation, sticky overrun
module vsync_frame_sel (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      vsync,
    input  logic                      busy,
    output frame_map_pkg::frame_cmd_t cmd,
    output logic                      overrun
);

    logic                              vsync_s1;   // first sync flop
    logic                              vsync_s2;   // second sync flop
    logic                              vsync_d;    // previous synced level
    logic                              frame_start;
    logic [frame_map_pkg::slot_w-1:0]  slot_q;     // next slot to read

    // two flop synchronizer, vsync comes from the display timing domain
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            vsync_s1 <= 1'b0;
            vsync_s2 <= 1'b0;
            vsync_d  <= 1'b0;
        end else begin
            vsync_s1 <= vsync;
            vsync_s2 <= vsync_s1;
            vsync_d  <= vsync_s2;
        end
    end

    assign frame_start = vsync_s2 && !vsync_d;   // rising edge

    // command register doubles as the edge register
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cmd     <= '0;
            slot_q  <= '0;
            overrun <= 1'b0;
        end else begin
            cmd.valid <= frame_start && !busy;
            cmd.slot  <= slot_q;
            if (frame_start) begin
                if (busy) begin
                    overrun <= 1'b1;   // frame dropped, slot kept
                end else begin
                    slot_q <= frame_map_pkg::next_slot(slot_q);
                end
            end
        end
    end

    // execute stage must still be idle when it sees the command
    a_cmd_idle: assert property (
        @(posedge clk) disable iff (!rst)
        cmd.valid |-> !busy
    );

endmodule

//--- hdl/frame_map_pkg.sv
// frame buffer layout, slot rotation and the frame address word
package frame_map_pkg;

    localparam int burst_len    = 4;                          // beats per burst
    localparam int burst_bytes  = 32;                         // burst_len * 8 bytes
    localparam int frame_bursts = 8;
    localparam int frame_beats  = frame_bursts * burst_len;   // 32
    localparam int slot_count   = 4;   // cam0 f0, cam1 f0, cam0 f1, cam1 f1
    localparam int credit_init  = 16;  // sink buffer depth in beats

    localparam int slot_w      = $clog2(slot_count);
    localparam int burst_idx_w = $clog2(frame_bursts);
    localparam int beat_cnt_w  = $clog2(frame_beats);
    localparam int credit_w    = $clog2(credit_init + 1);   // must hold credit_init itself

    // field view of a frame address, msb first
    typedef struct packed {
        logic [17:0]            upper;     // always zero
        logic [slot_w-1:0]      slot;      // slot base = slot * 4096
        logic [3:0]             pad;
        logic [burst_idx_w-1:0] burst;     // burst index within frame
        logic [1:0]             beat;      // beat within burst
        logic [2:0]             byte_off;  // byte within 64-bit beat
    } frame_addr_f_t;

    // same 32 bits seen as a flat byte address or as fields
    typedef union packed {
        logic [axi_rd_pkg::addr_w-1:0] flat;
        frame_addr_f_t                 f;
    } frame_addr_u;

    // frame start command from decode to execute
    typedef struct packed {
        logic              valid;
        logic [slot_w-1:0] slot;
    } frame_cmd_t;

    // fixed rotation 0 -> 1 -> 2 -> 3 -> 0
    function automatic logic [slot_w-1:0] next_slot(input logic [slot_w-1:0] slot);
        if (slot == slot_w'(slot_count - 1)) begin
            return '0;
        end
        return slot + 1'b1;
    endfunction

endpackage

//--- hdl/axi_rd_pkg.sv
// bus widths and the structs that travel between the read engine,
// the AXI read port and the display sink
package axi_rd_pkg;

    localparam int addr_w = 32;   // byte address
    localparam int data_w = 64;   // one beat
    localparam int id_w   = 2;    // id carries the frame slot

    // read address request, burst type/size/len fixed by the slave
    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] addr;
        logic [id_w-1:0]   id;
    } ar_req_t;

    // read data beat, rready is tied high
    typedef struct packed {
        logic              valid;
        logic [data_w-1:0] data;
        logic [id_w-1:0]   id;
        logic              last;   // final beat of a burst
    } r_beat_t;

    // beat stream toward the display sink
    typedef struct packed {
        logic              valid;
        logic [data_w-1:0] data;
        logic [id_w-1:0]   slot;   // frame slot the beat came from
        logic              sof;    // first beat of frame
        logic              eof;    // last beat of frame
    } pix_beat_t;

endpackage
